/* hw/chanlink_fifo.sv */
module chanlink_fifo import chanlink_pkg::*; #(
	parameter int L1A_DEPTH = 16,
	parameter int EVT_DEPTH = 256
)(
	input  logic                 RCLK,
	input  logic                 RST_RESYNC,
	input  logic                 fifo_rst_i,
	input  logic [SAMPLE_W-1:0]  wdata_i,
	input  logic                 ovlp_i,
	input  logic                 mlt_ovlp_i,
	input  logic                 wren_i,
	input  logic [L1A_CNT_W-1:0] l1a_cnt_i,
	input  logic                 l1a_phase_i,
	input  logic                 l1a_match_i,
	input  logic                 l1a_wrt_en_i,
	input  logic                 warn_i,
	input  logic [6:0]           samp_max_i,
	output logic [WORD_W-1:0]    dout_o,
	output logic                 dvalid_o,
	output logic                 last_wrd_o,
	output logic                 ovlp_mux_o,
	output logic                 mlt_ovlp_o
);

	if (L1A_DEPTH > 31) begin : g_depth_chk
		$error("L1A_DEPTH must fit the 5 bit occupancy field");
	end

	logic             l1a_push;
	logic             l1a_pop;
	logic             l1a_empty;
	logic [L1A_W-1:0] l1a_head;
	logic [4:0]       l1a_count;
	logic             evt_rd;
	logic             evt_empty;
	logic [EVT_W-1:0] evt_head;

	assign l1a_push = l1a_wrt_en_i & l1a_match_i;  // Only matched triggers

	frame_ctrl_if ctrl ();

	//////////////////////////////
	// Buffers
	//////////////////////////////
	sync_fifo #(.WIDTH(L1A_W), .DEPTH(L1A_DEPTH)) l1a_buf (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.clr_i(fifo_rst_i),
		.push_i(l1a_push),
		.pop_i(l1a_pop),
		.din_i({l1a_phase_i, l1a_cnt_i}),
		.dout_o(l1a_head),
		.empty_o(l1a_empty),
		.full_o(),
		.count_o(l1a_count)
	);

	sync_fifo #(.WIDTH(EVT_W), .DEPTH(EVT_DEPTH)) evt_buf (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.clr_i(fifo_rst_i),
		.push_i(wren_i),
		.pop_i(evt_rd),
		.din_i({mlt_ovlp_i, ovlp_i, wdata_i}),
		.dout_o(evt_head),
		.empty_o(evt_empty),
		.full_o(),
		.count_o()
	);

	//////////////////////////////
	// Readout
	//////////////////////////////
	frame_fsm u_fsm (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.l1a_empty_i(l1a_empty),
		.evt_empty_i(evt_empty),
		.evt_rd_o(evt_rd),
		.ctrl(ctrl.seq_mp)
	);

	assign l1a_pop = ctrl.last;  // Entry released with slot 99

	frame_formatter u_fmt (
		.RCLK(RCLK),
		.RST_RESYNC(RST_RESYNC),
		.ctrl(ctrl.fmt_mp),
		.evt_head_i(evt_head),
		.l1a_head_i(l1a_head),
		.l1a_count_i(l1a_count),
		.warn_i(warn_i),
		.samp_max_i(samp_max_i),
		.dout_o(dout_o),
		.dvalid_o(dvalid_o),
		.last_wrd_o(last_wrd_o),
		.ovlp_mux_o(ovlp_mux_o),
		.mlt_ovlp_o(mlt_ovlp_o)
	);

endmodule

/* hw/chanlink_pkg.sv */
package chanlink_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////
	localparam int SAMPLE_W  = 12;
	localparam int WORD_W    = 16;
	localparam int CRC_W     = 15;
	localparam int SEQ_W     = 7;
	localparam int L1A_CNT_W = 24;
	localparam int EVT_W     = SAMPLE_W + 2;   // Sample, overlap, multiple overlap
	localparam int L1A_W     = L1A_CNT_W + 1;  // L1A number plus phase on top

	//////////////////////////////
	// Frame layout
	//////////////////////////////
	localparam int unsigned DATA_WORDS = 96;

	localparam logic [SEQ_W-1:0] SEQ_CRC   = SEQ_W'(DATA_WORDS);  // First slot after data
	localparam logic [SEQ_W-1:0] SEQ_MARK  = 7'd97;
	localparam logic [SEQ_W-1:0] SEQ_TRAIL = 7'd98;
	localparam logic [SEQ_W-1:0] SEQ_LAST  = 7'd99;

	localparam logic [SEQ_W-1:0] PHASE_SEQ_FIRST = 7'd72;  // L1A phase on serial bit
	localparam logic [SEQ_W-1:0] PHASE_SEQ_LAST  = 7'd77;
	localparam logic [SEQ_W-1:0] SMAX_SEQ_FIRST  = 7'd90;  // Sample max flag on serial bit
	localparam logic [SEQ_W-1:0] SMAX_SEQ_LAST   = 7'd95;
	localparam logic [6:0]       SAMP_MAX_FULL   = 7'd15;

	localparam logic [WORD_W-1:0] MARK_WORD = 16'h700C;
	localparam logic [WORD_W-1:0] END_WORD  = 16'h7FFF;

	// One output word, seen as a data slot or as the trailer slot
	typedef union packed {
		struct packed {
			logic                zero_hi;
			logic                n_ovlp;    // Inverted overlap flag
			logic                serial;    // Slow status bit
			logic                zero_lo;
			logic [SAMPLE_W-1:0] sample;
		} data;
		struct packed {
			logic [3:0] nib;       // Always 7
			logic [5:0] l1a_num;   // Low bits of L1A number
			logic [4:0] occ;       // L1A buffer occupancy
			logic       warn;
		} trail;
	} frame_word_u;

	// Parallel CRC-15 over 13 data bits
	function automatic logic [CRC_W-1:0] crc15_d13(input logic [12:0] d, input logic [CRC_W-1:0] c);
		logic [CRC_W-1:0] nc;
		nc[0]  = d[0] ^ c[2];
		nc[1]  = d[0] ^ d[1] ^ c[2] ^ c[3];
		nc[2]  = d[1] ^ d[2] ^ c[3] ^ c[4];
		nc[3]  = d[2] ^ d[3] ^ c[4] ^ c[5];
		nc[4]  = d[3] ^ d[4] ^ c[5] ^ c[6];
		nc[5]  = d[4] ^ d[5] ^ c[6] ^ c[7];
		nc[6]  = d[5] ^ d[6] ^ c[7] ^ c[8];
		nc[7]  = d[6] ^ d[7] ^ c[8] ^ c[9];
		nc[8]  = d[7] ^ d[8] ^ c[9] ^ c[10];
		nc[9]  = d[8] ^ d[9] ^ c[10] ^ c[11];
		nc[10] = d[9] ^ d[10] ^ c[11] ^ c[12];
		nc[11] = d[10] ^ d[11] ^ c[12] ^ c[13];
		nc[12] = d[11] ^ d[12] ^ c[13] ^ c[14];
		nc[13] = d[12] ^ c[14] ^ c[0];
		nc[14] = c[1];
		return nc;
	endfunction

endpackage

/* hw/frame_ctrl_if.sv */
interface frame_ctrl_if import chanlink_pkg::*; ();

	//////////////////////////////
	// Slot control, all in one cycle
	//////////////////////////////
	logic [SEQ_W-1:0] seq;   // Slot number 0 to 99
	logic             valid; // Slot issued this cycle
	logic             clr_crc; // One cycle ahead of slot 0
	logic             last;  // With slot 99

	modport seq_mp (
		output seq,
		output valid,
		output clr_crc,
		output last
	);

	modport fmt_mp (
		input seq,
		input valid,
		input clr_crc,
		input last
	);

endinterface

/* hw/frame_formatter.sv */
module frame_formatter import chanlink_pkg::*; (
	input  logic              RCLK,
	input  logic              RST_RESYNC,
	frame_ctrl_if.fmt_mp      ctrl,
	input  logic [EVT_W-1:0]  evt_head_i,
	input  logic [L1A_W-1:0]  l1a_head_i,
	input  logic [4:0]        l1a_count_i,
	input  logic              warn_i,
	input  logic [6:0]        samp_max_i,
	output logic [WORD_W-1:0] dout_o,
	output logic              dvalid_o,
	output logic              last_wrd_o,
	output logic              ovlp_mux_o,
	output logic              mlt_ovlp_o
);

	logic             serial;
	frame_word_u      data_w;   // Data view of current head
	frame_word_u      trail_w;  // Trailer view
	frame_word_u      word1;
	logic [SEQ_W-1:0] seq1;
	logic             mlt1;
	logic             valid1;
	logic             last1;
	logic             data1;
	logic [CRC_W-1:0] crc;

	//////////////////////////////
	// Word building
	//////////////////////////////
	always_comb begin
		if (ctrl.seq >= PHASE_SEQ_FIRST && ctrl.seq <= PHASE_SEQ_LAST) begin
			serial = l1a_head_i[L1A_CNT_W];              // L1A phase
		end else if (ctrl.seq >= SMAX_SEQ_FIRST && ctrl.seq <= SMAX_SEQ_LAST) begin
			serial = (samp_max_i == SAMP_MAX_FULL);
		end else begin
			serial = 1'b0;
		end
	end

	always_comb begin
		data_w.data.zero_hi = 1'b0;
		data_w.data.n_ovlp  = ~evt_head_i[SAMPLE_W];
		data_w.data.serial  = serial;
		data_w.data.zero_lo = 1'b0;
		data_w.data.sample  = evt_head_i[SAMPLE_W-1:0];
	end

	always_comb begin
		trail_w.trail.nib     = 4'h7;
		trail_w.trail.l1a_num = l1a_head_i[5:0];
		trail_w.trail.occ     = l1a_count_i;       // Still counts the entry in readout
		trail_w.trail.warn    = warn_i;
	end

	//////////////////////////////
	// Stage 1
	//////////////////////////////
	always_ff @(posedge RCLK) begin
		if (ctrl.valid) begin
			word1 <= data_w;
			seq1  <= ctrl.seq;
			mlt1  <= evt_head_i[SAMPLE_W+1];
		end
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			valid1 <= 1'b0;
			last1  <= 1'b0;
		end else begin
			valid1 <= ctrl.valid;
			last1  <= ctrl.last;
		end
	end

	assign data1 = valid1 && (seq1 < SEQ_CRC);

	// CRC over the registered samples of the frame
	always_ff @(posedge RCLK) begin
		if (ctrl.clr_crc) begin
			crc <= '0;
		end else if (data1) begin
			crc <= crc15_d13({1'b0, word1.data.sample}, crc);
		end
	end

	//////////////////////////////
	// Stage 2
	//////////////////////////////
	always_ff @(posedge RCLK) begin
		if (valid1) begin
			case (seq1)
				SEQ_CRC:   dout_o <= {1'b0, crc};
				SEQ_MARK:  dout_o <= MARK_WORD;
				SEQ_TRAIL: dout_o <= trail_w;
				SEQ_LAST:  dout_o <= END_WORD;
				default:   dout_o <= word1;
			endcase
		end
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			dvalid_o   <= 1'b0;
			last_wrd_o <= 1'b0;
			ovlp_mux_o <= 1'b0;
			mlt_ovlp_o <= 1'b0;
		end else begin
			dvalid_o   <= valid1;
			last_wrd_o <= last1;
			mlt_ovlp_o <= data1 && mlt1;
			if (data1) begin
				ovlp_mux_o <= word1.data.n_ovlp;  // Held through trailer
			end
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////
	a_last_word : assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		last_wrd_o |-> dvalid_o && dout_o == END_WORD)
		else $error("Last word flag off the closing word");

endmodule

/* hw/frame_fsm.sv */
module frame_fsm import chanlink_pkg::*; (
	input  logic         RCLK,
	input  logic         RST_RESYNC,
	input  logic         l1a_empty_i,
	input  logic         evt_empty_i,
	output logic         evt_rd_o,
	frame_ctrl_if.seq_mp ctrl
);

	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_CLEAR = 2'd1;
	localparam logic [1:0] ST_FRAME = 2'd2;

	logic [1:0]       state;
	logic [SEQ_W-1:0] seq;
	logic             data_slot;
	logic             issue;

	//////////////////////////////
	// Slot issue
	//////////////////////////////
	assign data_slot = (seq < SEQ_CRC);
	// Data slots wait for a sample, trailer slots never wait
	assign issue     = (state == ST_FRAME) && (!data_slot || !evt_empty_i);

	assign evt_rd_o     = issue && data_slot;
	assign ctrl.seq     = seq;
	assign ctrl.valid   = issue;
	assign ctrl.clr_crc = (state == ST_CLEAR);
	assign ctrl.last    = issue && (seq == SEQ_LAST);   // Also pops the L1A entry

	//////////////////////////////
	// State and slot counter
	//////////////////////////////
	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			state <= ST_IDLE;
			seq   <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (!l1a_empty_i && !evt_empty_i) begin  // Trigger and first sample ready
						state <= ST_CLEAR;
					end
				end
				ST_CLEAR: begin
					state <= ST_FRAME;
					seq   <= '0;
				end
				ST_FRAME: begin
					if (issue) begin
						if (seq == SEQ_LAST) begin
							state <= ST_IDLE;
							seq   <= '0;
						end else begin
							seq <= seq + SEQ_W'(1);
						end
					end
				end
				default: begin
					state <= ST_IDLE;
					seq   <= '0;
				end
			endcase
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////
	a_seq_range : assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		ctrl.valid |-> ctrl.seq <= SEQ_LAST)
		else $error("Slot number beyond end of frame");

endmodule

/* hw/sync_fifo.sv */
module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
)(
	input  logic             RCLK,
	input  logic             RST_RESYNC,
	input  logic             clr_i,
	input  logic             push_i,
	input  logic             pop_i,
	input  logic [WIDTH-1:0] din_i,
	output logic [WIDTH-1:0] dout_o,
	output logic             empty_o,
	output logic             full_o,
	output logic [4:0]       count_o
);

	localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W  = $clog2(DEPTH + 1);
	localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(DEPTH - 1);

	logic [WIDTH-1:0]  mem [DEPTH];
	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	logic [CNT_W-1:0]  count;
	logic              wr_en;
	logic              rd_en;

	assign wr_en   = push_i && !full_o;    // Push while full is dropped
	assign rd_en   = pop_i && !empty_o;
	assign empty_o = (count == '0);
	assign full_o  = (count == CNT_W'(DEPTH));
	assign dout_o  = mem[rd_ptr];          // Head shown ahead of the pop
	assign count_o = (32'(count) > 32'd31) ? 5'd31 : 5'(count);  // Saturates for deep buffers

	always_ff @(posedge RCLK) begin
		if (wr_en) begin
			mem[wr_ptr] <= din_i;
		end
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (clr_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == LAST_ADDR) ? '0 : wr_ptr + ADDR_W'(1);
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == LAST_ADDR) ? '0 : rd_ptr + ADDR_W'(1);
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + CNT_W'(1);
				2'b01:   count <= count - CNT_W'(1);
				default: count <= count;  // Idle or push with pop
			endcase
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////
	a_push_full : assert property (@(posedge RCLK) disable iff (RST_RESYNC || clr_i)
		!(push_i && full_o))
		else $error("Push into full FIFO, entry lost");

	a_pop_empty : assert property (@(posedge RCLK) disable iff (RST_RESYNC || clr_i)
		!(pop_i && empty_o))
		else $error("Pop from empty FIFO");

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the channel link testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_chanlink \
	--Mdir obj_dir -o tb_chanlink
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_chanlink > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed, see $LOG"
exit 1

/* verification/chanlink_model.svh */
`ifndef CHANLINK_MODEL_SVH
`define CHANLINK_MODEL_SVH

//////////////////////////////
// Reference queues
//////////////////////////////
logic [EVT_W-1:0] samp_q[$];  // {mlt, ovlp, sample}, oldest first
logic [L1A_W-1:0] l1a_q[$];   // {phase, number} of matched triggers
int               occ_q[$];   // Expected occupancy, -1 when not predicted

logic [L1A_W-1:0] cur_l1a;
int               cur_occ;
logic [CRC_W-1:0] cur_crc;
logic             cur_novlp;   // Inverted overlap of the latest data word

task automatic open_frame();
	cur_l1a = l1a_q.pop_front();
	cur_occ = occ_q.pop_front();
	cur_crc = '0;
endtask

// Expected word, compare mask and markers for one slot
task automatic expect_slot(input int idx, input logic warn, input logic [6:0] smax,
	output logic [WORD_W-1:0] word, output logic [WORD_W-1:0] mask,
	output logic mlt, output logic novlp);
	logic [EVT_W-1:0] ev;
	logic             serial;
	logic [4:0]       occ;
	mask = 16'hFFFF;
	mlt  = 1'b0;
	if (idx < 96) begin
		ev = samp_q.pop_front();
		if (idx >= 72 && idx <= 77) begin
			serial = cur_l1a[L1A_CNT_W];   // Trigger phase
		end else if (idx >= 90 && idx <= 95) begin
			serial = (smax == 7'd15);
		end else begin
			serial = 1'b0;
		end
		word      = {1'b0, ~ev[SAMPLE_W], serial, 1'b0, ev[SAMPLE_W-1:0]};
		mlt       = ev[SAMPLE_W+1];
		cur_novlp = ~ev[SAMPLE_W];
		cur_crc   = crc15_d13({1'b0, ev[SAMPLE_W-1:0]}, cur_crc);
	end else if (idx == 96) begin
		word = {1'b0, cur_crc};
	end else if (idx == 97) begin
		word = 16'h700C;
	end else if (idx == 98) begin
		occ  = (cur_occ < 0) ? 5'd0 : 5'(cur_occ);
		word = {4'h7, cur_l1a[5:0], occ, warn};
		if (cur_occ < 0) begin
			mask = 16'hFFC1;   // Occupancy field not predicted
		end
	end else begin
		word = 16'h7FFF;
	end
	novlp = cur_novlp;
endtask

`endif

/* verification/tb_chanlink.sv */
module tb_chanlink import chanlink_pkg::*; ();

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 8;
	localparam int PHASES       = 6;
	localparam int FRAME_CYCLES = 100;
	localparam int MAX_FRAMES   = 24;   // Three loads of up to 5, three trickles of 2
	localparam int STALL_FACTOR = 4;

	logic                 RCLK;
	logic                 RST_RESYNC;
	logic                 fifo_rst;
	logic [SAMPLE_W-1:0]  wdata;
	logic                 ovlp;
	logic                 mlt_ovlp;
	logic                 wren;
	logic [L1A_CNT_W-1:0] l1a_cnt;
	logic                 l1a_phase;
	logic                 l1a_match;
	logic                 l1a_wrt_en;
	logic                 warn;
	logic [6:0]           samp_max;
	logic [WORD_W-1:0]    dout;
	logic                 dvalid;
	logic                 last_wrd;
	logic                 ovlp_mux;
	logic                 mlt_out;

	integer seed;
	int     slot;          // Next expected word within the frame
	int     frames_seen;
	int     matched;
	int     phase_idx;

	`include "chanlink_model.svh"

	chanlink_fifo #(.L1A_DEPTH(16), .EVT_DEPTH(256)) uut (
		.RCLK(RCLK), .RST_RESYNC(RST_RESYNC), .fifo_rst_i(fifo_rst),
		.wdata_i(wdata), .ovlp_i(ovlp), .mlt_ovlp_i(mlt_ovlp), .wren_i(wren),
		.l1a_cnt_i(l1a_cnt), .l1a_phase_i(l1a_phase), .l1a_match_i(l1a_match),
		.l1a_wrt_en_i(l1a_wrt_en), .warn_i(warn), .samp_max_i(samp_max),
		.dout_o(dout), .dvalid_o(dvalid), .last_wrd_o(last_wrd),
		.ovlp_mux_o(ovlp_mux), .mlt_ovlp_o(mlt_out)
	);

	always #(CLK_PERIOD / 2) RCLK = ~RCLK;

	//////////////////////////////
	// Failure reporting
	//////////////////////////////
	task automatic stop_run();
		$display("** FAIL **");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected) begin
			$display("Error at time %0t: %s, got 0x%0h, expected 0x%0h", $time, msg,
				actual, expected);
			stop_run();
		end
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	task automatic drive_cycle(input logic push_l1a, input logic match, input logic push_evt,
		input int occ);
		logic [EVT_W-1:0] ev;
		logic [L1A_W-1:0] ent;
		logic [31:0]      rnd;
		@(negedge RCLK);
		ev         = EVT_W'($random(seed));
		ent        = L1A_W'($random(seed));
		rnd        = $random(seed);
		wren       = push_evt;
		wdata      = ev[SAMPLE_W-1:0];
		ovlp       = ev[SAMPLE_W];
		mlt_ovlp   = ev[SAMPLE_W+1];
		l1a_wrt_en = push_l1a;
		l1a_match  = push_l1a ? match : rnd[0];   // Match alone must not push
		l1a_cnt    = ent[L1A_CNT_W-1:0];
		l1a_phase  = ent[L1A_CNT_W];
		if (push_evt) begin
			samp_q.push_back(ev);
		end
		if (push_l1a && match) begin
			l1a_q.push_back(ent);
			occ_q.push_back(occ);
			matched++;
		end
	endtask

	// Triggers first, then samples at full rate, so occupancy only falls
	task automatic load_drain(input int n);
		int k;
		k = 0;
		while (k < n) begin
			if (({$random(seed)} % 4) == 0) begin
				drive_cycle(1'b1, 1'b0, 1'b0, -1);   // Unmatched trigger
			end else begin
				drive_cycle(1'b1, 1'b1, 1'b0, n - k);
				k++;
			end
		end
		for (k = 0; k < n * 96; k++) begin
			drive_cycle(1'b0, 1'b0, 1'b1, -1);
		end
		drive_cycle(1'b0, 1'b0, 1'b0, -1);
	endtask

	// Samples with random gaps, triggers mixed in
	task automatic trickle(input int m);
		int   s;
		int   t;
		int   trig;
		logic go_evt;
		s    = 0;
		t    = 0;
		trig = {$random(seed)} % 96;
		while (s < m * 96 || t < m) begin
			go_evt = (s < m * 96) && 1'($random(seed));
			if (t < m && s >= trig) begin
				drive_cycle(1'b1, 1'b1, go_evt, -1);
				t++;
				trig = t * 96 + {$random(seed)} % 96;
			end else begin
				drive_cycle(({$random(seed)} % 24) == 0, 1'b0, go_evt, -1);
			end
			if (go_evt) begin
				s++;
			end
		end
		drive_cycle(1'b0, 1'b0, 1'b0, -1);
	endtask

	//////////////////////////////
	// Output checker
	//////////////////////////////
	task automatic check_output();
		logic [WORD_W-1:0] word;
		logic [WORD_W-1:0] mask;
		logic              mlt;
		logic              novlp;
		if (!dvalid) begin
			if (slot >= 96) begin
				check_equal(32'(dvalid), 32'd1, "dvalid_o dropped inside the trailer");
			end
			check_equal(32'(last_wrd), 32'd0, "last_wrd_o high without dvalid_o");
		end else begin
			if (slot == 0 && l1a_q.size() == 0) begin
				$display("A frame came out with no matched L1A entry pending");
				stop_run();
			end
			if (slot < 96 && samp_q.size() == 0) begin
				$display("A data word came out with no sample pending");
				stop_run();
			end
			if (slot == 0) begin
				open_frame();
			end
			expect_slot(slot, warn, samp_max, word, mask, mlt, novlp);
			check_equal(32'(dout & mask), 32'(word & mask),
				$sformatf("word %0d of frame %0d", slot, frames_seen));
			check_equal(32'(last_wrd), 32'(slot == 99), "last_wrd_o position");
			check_equal(32'(mlt_out), 32'(mlt), $sformatf("mlt_ovlp_o at word %0d", slot));
			check_equal(32'(ovlp_mux), 32'(novlp), $sformatf("ovlp_mux_o at word %0d", slot));
			slot++;
			if (slot == 100) begin
				slot = 0;
				frames_seen++;
			end
		end
	endtask

	always @(negedge RCLK) begin
		if (!RST_RESYNC) begin
			check_output();
		end
	end

	initial begin
		#(CLK_PERIOD * (RESET_CYCLES + MAX_FRAMES * FRAME_CYCLES * STALL_FACTOR));
		$display("Timeout: the expected frames did not all come out in time");
		stop_run();
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		seed        = 33;
		slot        = 0;
		frames_seen = 0;
		matched     = 0;
		RCLK        = 1'b0;
		RST_RESYNC  = 1'b1;
		fifo_rst    = 1'b0;
		wdata       = '0;
		ovlp        = 1'b0;
		mlt_ovlp    = 1'b0;
		wren        = 1'b0;
		l1a_cnt     = '0;
		l1a_phase   = 1'b0;
		l1a_match   = 1'b0;
		l1a_wrt_en  = 1'b0;
		warn        = 1'b0;
		samp_max    = '0;
		repeat (RESET_CYCLES) @(posedge RCLK);
		@(negedge RCLK);
		RST_RESYNC = 1'b0;
		for (phase_idx = 0; phase_idx < PHASES; phase_idx++) begin
			@(negedge RCLK);
			warn     = 1'($random(seed));   // Held for the whole phase
			samp_max = 1'($random(seed)) ? 7'd15 : 7'({$random(seed)} % 15);
			if (phase_idx % 2 == 0) begin
				load_drain(2 + {$random(seed)} % 4);
			end else begin
				trickle(2);
			end
			wait (frames_seen == matched);
			repeat (4) @(negedge RCLK);
		end
		repeat (20) @(negedge RCLK);
		$display("** PASS **");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+verification
hw/chanlink_pkg.sv
hw/frame_ctrl_if.sv
hw/sync_fifo.sv
hw/frame_fsm.sv
hw/frame_formatter.sv
hw/chanlink_fifo.sv
verification/tb_chanlink.sv
